//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_clock_monitor
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := TESTBENCH FAILED
PASS_MSG  := TESTBENCH PASSED
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- chan_report_if.sv
`timescale 1ns/1ps
`default_nettype none

interface chan_report_if import clkmon_types_pkg::*; ();

   freq_t freq;    // edges counted in the last window
   logic  alive;   // last window saw at least one edge
   logic  change;  // sticky step flag
   logic  update;  // one cycle, new values valid from here

   modport source (
      output freq,
      output alive,
      output change,
      output update
   );

   modport sink (
      input freq,
      input alive,
      input change,
      input update
   );

endinterface

`default_nettype wire

//--- clkmon_types_pkg.sv
`default_nettype none

package clkmon_types_pkg;

   localparam int FREQ_W     = 32;
   localparam int LIMIT_W    = 32;
   localparam int CHAN_SEL_W = 2;  // caps the design at 4 channels

   // rising edges of one monitored clock per gate window
   typedef logic [FREQ_W-1:0] freq_t;

   // allowed step between two consecutive measurements
   typedef logic [LIMIT_W-1:0] limit_t;

   // readout channel index
   typedef logic [CHAN_SEL_W-1:0] chan_sel_t;

endpackage

`default_nettype wire

//--- clock_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module clock_monitor import clkmon_types_pkg::*; import led_pkg::*; #(
   parameter int NUM_CH     = 3,   // 1..4
   parameter int TIMER_BITS = 26   // window is 2**(TIMER_BITS-3) cycles
) (
   input  wire logic              clk_usb,
   input  wire logic              reset,
   input  wire logic [NUM_CH-1:0] ext_clk_i,
   input  wire logic              monitor_disable_i,
   input  wire limit_t            change_limit_i,
   input  wire chan_sel_t         freq_sel_i,
   input  wire led_sel_t          led_select_i,
   output freq_t                  freq_o,
   output logic                   freq_valid_o,
   output logic                   freq_measure_o,
   output logic [NUM_CH-1:0]      change_o,
   output logic                   clk_change_o,
   output logic                   led_a_o,
   output logic                   led_b_o
);

   logic meas_strobe;
   logic heartbeat;
   logic flash;

   chan_report_if reports [NUM_CH] ();

   heartbeat_timer #(
      .TIMER_BITS (TIMER_BITS)
   ) heartbeat_timer_inst (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .meas_strobe_o (meas_strobe),
      .heartbeat_o   (heartbeat),
      .flash_o       (flash)
   );

   for (genvar i = 0; i < NUM_CH; i++) begin : g_chan
      freq_channel freq_channel_inst (
         .clk_usb           (clk_usb),
         .reset             (reset),
         .ext_clk_i         (ext_clk_i[i]),
         .meas_strobe_i     (meas_strobe),
         .monitor_disable_i (monitor_disable_i),
         .change_limit_i    (change_limit_i),
         .report            (reports[i])
      );
   end

   clock_status #(
      .NUM_CH (NUM_CH)
   ) clock_status_inst (
      .clk_usb      (clk_usb),
      .reset        (reset),
      .reports      (reports),
      .heartbeat_i  (heartbeat),
      .flash_i      (flash),
      .freq_sel_i   (freq_sel_i),
      .led_select_i (led_select_i),
      .freq_o       (freq_o),
      .freq_valid_o (freq_valid_o),
      .change_o     (change_o),
      .clk_change_o (clk_change_o),
      .led_a_o      (led_a_o),
      .led_b_o      (led_b_o)
   );

   assign freq_measure_o = meas_strobe;  // window boundary for software

endmodule

`default_nettype wire

//--- clock_status.sv
`timescale 1ns/1ps
`default_nettype none

module clock_status import clkmon_types_pkg::*; import led_pkg::*; #(
   parameter int NUM_CH = 3
) (
   input  wire logic      clk_usb,
   input  wire logic      reset,
   chan_report_if.sink    reports [NUM_CH],
   input  wire logic      heartbeat_i,
   input  wire logic      flash_i,
   input  wire chan_sel_t freq_sel_i,
   input  wire led_sel_t  led_select_i,
   output freq_t          freq_o,
   output logic           freq_valid_o,
   output logic [NUM_CH-1:0] change_o,
   output logic           clk_change_o,
   output logic           led_a_o,
   output logic           led_b_o
);

   freq_t             ch_freq [NUM_CH];
   logic [NUM_CH-1:0] ch_alive;
   logic [NUM_CH-1:0] ch_change;
   logic [NUM_CH-1:0] ch_update;
   led_sel_t          led_ch;

   // interface arrays need constant indices, flatten them first
   for (genvar i = 0; i < NUM_CH; i++) begin : g_flat
      assign ch_freq[i]   = reports[i].freq;
      assign ch_alive[i]  = reports[i].alive;
      assign ch_change[i] = reports[i].change;
      assign ch_update[i] = reports[i].update;
   end

   always_comb begin
      if (int'(freq_sel_i) < NUM_CH) begin
         freq_o       = ch_freq[freq_sel_i];
         freq_valid_o = ch_update[freq_sel_i];
      end else begin
         freq_o       = '0;
         freq_valid_o = 1'b0;
      end
   end

   assign change_o     = ch_change;
   assign clk_change_o = |ch_change;

   assign led_ch = led_select_i - 1'b1;  // select k shows channel k-1

   always_comb begin
      led_a_o = 1'b0;
      led_b_o = 1'b0;
      if (led_select_i == LED_SEL_SYSTEM) begin
         if (clk_change_o) begin
            led_a_o = flash_i;
            led_b_o = flash_i;
         end else begin
            led_a_o = heartbeat_i;
         end
      end else if (int'(led_select_i) <= NUM_CH) begin
         led_a_o = ch_alive[led_ch];
         led_b_o = ch_change[led_ch];
      end
   end

   a_freq_sel_range : assert property (
      @(posedge clk_usb) disable iff (reset)
      int'(freq_sel_i) < NUM_CH
   );

endmodule

`default_nettype wire

//--- freq_channel.sv
`timescale 1ns/1ps
`default_nettype none

module freq_channel import clkmon_types_pkg::*; (
   input  wire logic   clk_usb,
   input  wire logic   reset,
   input  wire logic   ext_clk_i,
   input  wire logic   meas_strobe_i,
   input  wire logic   monitor_disable_i,
   input  wire limit_t change_limit_i,
   chan_report_if.source report
);

   logic [2:0] sync_q;      // [1:0] synchronizer, [2] edge register
   logic       rise;
   freq_t      edge_cnt;
   freq_t      delta;
   logic       have_prev;   // one measurement already latched
   logic       step_seen;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[1:0], ext_clk_i};
      end
   end

   assign rise = sync_q[1] & ~sync_q[2];

   // edge in the strobe cycle opens the new window
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         edge_cnt <= '0;
      end else if (meas_strobe_i) begin
         edge_cnt <= freq_t'(rise);
      end else begin
         edge_cnt <= edge_cnt + freq_t'(rise);
      end
   end

   // |old - new|
   always_comb begin
      if (report.freq > edge_cnt) begin
         delta = report.freq - edge_cnt;
      end else begin
         delta = edge_cnt - report.freq;
      end
   end

   assign step_seen = have_prev && (delta > change_limit_i);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         report.freq   <= '0;
         report.alive  <= 1'b0;
         report.update <= 1'b0;
         have_prev     <= 1'b0;
      end else begin
         report.update <= meas_strobe_i;
         if (meas_strobe_i) begin
            report.freq  <= edge_cnt;
            report.alive <= (edge_cnt != '0);
            have_prev    <= 1'b1;
         end
      end
   end

   // sticky until software disables the monitor
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         report.change <= 1'b0;
      end else if (monitor_disable_i) begin
         report.change <= 1'b0;  // disable wins over a new step
      end else if (meas_strobe_i && step_seen) begin
         report.change <= 1'b1;
      end
   end

   a_disable_clears : assert property (
      @(posedge clk_usb) disable iff (reset)
      monitor_disable_i |=> !report.change
   );

endmodule

`default_nettype wire

//--- heartbeat_timer.sv
`timescale 1ns/1ps
`default_nettype none

module heartbeat_timer #(
   parameter int TIMER_BITS = 26
) (
   input  wire logic clk_usb,
   input  wire logic reset,
   output logic      meas_strobe_o,
   output logic      heartbeat_o,
   output logic      flash_o
);

   localparam int STROBE_BIT = TIMER_BITS - 4;
   localparam int HEART_BIT  = TIMER_BITS - 2;
   localparam int FLASH_EN   = TIMER_BITS - 1;
   localparam int FLASH_BIT  = TIMER_BITS - 3;

   logic [TIMER_BITS-1:0] timer;
   logic                  strobe_bit_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer         <= '0;
         strobe_bit_q  <= 1'b0;
         meas_strobe_o <= 1'b0;
      end else begin
         timer         <= timer + 1'b1;  // free running, wraps
         strobe_bit_q  <= timer[STROBE_BIT];
         meas_strobe_o <= timer[STROBE_BIT] & ~strobe_bit_q;
      end
   end

   // blinks only during the upper half of the timer period
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         flash_o <= 1'b0;
      end else if (timer[FLASH_EN]) begin
         flash_o <= ~timer[FLASH_BIT];
      end
   end

   assign heartbeat_o = timer[HEART_BIT];

   // the strobe bit stays set for many cycles, so the pulse must be single
   a_strobe_single : assert property (
      @(posedge clk_usb) disable iff (reset)
      meas_strobe_o |=> !meas_strobe_o
   );

endmodule

`default_nettype wire

//--- led_pkg.sv
`default_nettype none

package led_pkg;

   localparam int LED_SEL_W = 2;

   typedef logic [LED_SEL_W-1:0] led_sel_t;

   // heartbeat/flash view, codes 1..NUM_CH pick a channel
   localparam led_sel_t LED_SEL_SYSTEM = led_sel_t'(0);

endpackage

`default_nettype wire

//--- src.f
clkmon_types_pkg.sv
led_pkg.sv
chan_report_if.sv
heartbeat_timer.sv
freq_channel.sv
clock_status.sv
clock_monitor.sv
tb_clock_monitor.sv

//--- tb_clock_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_monitor import clkmon_types_pkg::*; import led_pkg::*; ();

   localparam int NUM_CH     = 3;
   localparam int TIMER_BITS = 10;
   localparam int WINDOW     = 2 ** (TIMER_BITS - 3);  // cycles per gate window
   localparam int NUM_ROWS   = 11;
   localparam int LED_ANY    = 0;
   localparam int LED_EXACT  = 1;
   localparam int LED_EQUAL  = 2;

   logic              clk_usb;
   logic              reset;
   logic [NUM_CH-1:0] ext_clk;
   logic              monitor_disable_i;
   limit_t            change_limit_i;
   chan_sel_t         freq_sel_i;
   led_sel_t          led_select_i;
   freq_t             freq_o;
   logic              freq_valid_o;
   logic              freq_measure_o;
   logic [NUM_CH-1:0] change_o;
   logic              clk_change_o;
   logic              led_a_o;
   logic              led_b_o;

   // stimulus table
   string             row_name [NUM_ROWS];
   int                row_half [NUM_ROWS][NUM_CH];  // half period 0 means stopped
   int                row_limit [NUM_ROWS];
   logic              row_dis [NUM_ROWS];
   int                row_led [NUM_ROWS];
   int                row_fsel [NUM_ROWS];
   int                row_nwin [NUM_ROWS];
   logic [NUM_CH-1:0] row_chg [NUM_ROWS];
   int                row_led_mode [NUM_ROWS];
   logic              row_led_a [NUM_ROWS];
   logic              row_led_b [NUM_ROWS];
   int                num_rows;

   int                cur_half [NUM_CH];
   int                ph_cnt [NUM_CH];
   int                start_dly [NUM_CH];
   logic [31:0]       rng_state;
   int                cycle_cnt;
   int                cycle_limit;
   int                since_strobe;
   logic              strobe_seen;
   logic              strobe_d;

   clock_monitor #(
      .NUM_CH     (NUM_CH),
      .TIMER_BITS (TIMER_BITS)
   ) clock_monitor_inst (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .ext_clk_i         (ext_clk),
      .monitor_disable_i (monitor_disable_i),
      .change_limit_i    (change_limit_i),
      .freq_sel_i        (freq_sel_i),
      .led_select_i      (led_select_i),
      .freq_o            (freq_o),
      .freq_valid_o      (freq_valid_o),
      .freq_measure_o    (freq_measure_o),
      .change_o          (change_o),
      .clk_change_o      (clk_change_o),
      .led_a_o           (led_a_o),
      .led_b_o           (led_b_o)
   );

   always #5 clk_usb = ~clk_usb;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int expected_count(input int half);
      if (half == 0) begin
         return 0;
      end
      return WINDOW / (2 * half);
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic add_row(input string name, input int h0, input int h1, input int h2,
                          input int limit, input logic dis, input int led, input int fsel,
                          input int nwin, input logic [NUM_CH-1:0] chg, input int led_mode,
                          input logic led_a, input logic led_b);
      row_name[num_rows]     = name;
      row_half[num_rows][0]  = h0;
      row_half[num_rows][1]  = h1;
      row_half[num_rows][2]  = h2;
      row_limit[num_rows]    = limit;
      row_dis[num_rows]      = dis;
      row_led[num_rows]      = led;
      row_fsel[num_rows]     = fsel;
      row_nwin[num_rows]     = nwin;
      row_chg[num_rows]      = chg;
      row_led_mode[num_rows] = led_mode;
      row_led_a[num_rows]    = led_a;
      row_led_b[num_rows]    = led_b;
      num_rows++;
   endtask

   task automatic apply_row(input int r);
      for (int ch = 0; ch < NUM_CH; ch++) begin
         cur_half[ch] <= row_half[r][ch];  // generator sees it from next falling edge
      end
      change_limit_i    = limit_t'(row_limit[r]);
      monitor_disable_i = row_dis[r];
      led_select_i      = led_sel_t'(row_led[r]);
      freq_sel_i        = chan_sel_t'(row_fsel[r]);
   endtask

   task automatic wait_valid(input string name);
      int guard;
      guard = 0;
      @(negedge clk_usb);
      while (freq_valid_o !== 1'b1) begin
         guard++;
         if (guard > 2 * WINDOW + 10) begin
            fail_run($sformatf("%s: no freq_valid_o pulse within two windows", name));
         end
         @(negedge clk_usb);
      end
   endtask

   task automatic check_freq(input int r);
      int exp_cnt;
      int act_cnt;
      exp_cnt = expected_count(row_half[r][row_fsel[r]]);
      act_cnt = int'(freq_o);
      assert (act_cnt >= exp_cnt - 1 && act_cnt <= exp_cnt + 1)
         else fail_run($sformatf("mismatch %s freq_o: expected %0d actual %0d",
                                 row_name[r], exp_cnt, act_cnt));
   endtask

   task automatic check_row_end(input int r);
      assert (change_o == row_chg[r])
         else fail_run($sformatf("mismatch %s change_o: expected %b actual %b",
                                 row_name[r], row_chg[r], change_o));
      assert (clk_change_o == |row_chg[r])
         else fail_run($sformatf("mismatch %s clk_change_o: expected %b actual %b",
                                 row_name[r], |row_chg[r], clk_change_o));
      if (row_led_mode[r] == LED_EXACT) begin
         assert (led_a_o == row_led_a[r] && led_b_o == row_led_b[r])
            else fail_run($sformatf("mismatch %s leds: expected %b%b actual %b%b", row_name[r],
                                    row_led_a[r], row_led_b[r], led_a_o, led_b_o));
      end else if (row_led_mode[r] == LED_EQUAL) begin
         assert (led_a_o == led_b_o)  // both show flash
            else fail_run($sformatf("mismatch %s led_b_o: expected %b actual %b",
                                    row_name[r], led_a_o, led_b_o));
      end
   endtask

   // external clocks toggle on falling edges
   always @(negedge clk_usb) begin
      for (int i = 0; i < NUM_CH; i++) begin
         if (start_dly[i] > 0) begin
            start_dly[i]--;
         end else if (cur_half[i] == 0) begin
            ext_clk[i] = 1'b0;
         end else if (ph_cnt[i] >= cur_half[i] - 1) begin
            ext_clk[i] = ~ext_clk[i];
            ph_cnt[i] = 0;
         end else begin
            ph_cnt[i]++;
         end
      end
   end

   // strobe spacing and valid alignment
   always @(negedge clk_usb) begin
      if (reset) begin
         since_strobe = 0;
         strobe_seen  = 1'b0;
         strobe_d     = 1'b0;
      end else begin
         since_strobe++;
         assert (freq_valid_o == strobe_d)
            else fail_run($sformatf("mismatch strobe_follow freq_valid_o: expected %b actual %b",
                                    strobe_d, freq_valid_o));
         if (freq_measure_o) begin
            if (strobe_seen) begin
               assert (since_strobe == WINDOW)
                  else fail_run($sformatf("mismatch strobe_spacing cycles: expected %0d actual %0d",
                                          WINDOW, since_strobe));
            end
            strobe_seen  = 1'b1;
            since_strobe = 0;
         end
         strobe_d = freq_measure_o;
      end
   end

   always @(posedge clk_usb) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         fail_run($sformatf("timeout after %0d cycles, rows did not finish", cycle_cnt));
      end
   end

   initial begin
      int   prev_half [NUM_CH];
      logic changed;
      int   total_win;
      clk_usb           = 1'b0;
      reset             = 1'b1;
      ext_clk           = '0;
      monitor_disable_i = 1'b0;
      change_limit_i    = limit_t'(40);
      freq_sel_i        = '0;
      led_select_i      = LED_SEL_SYSTEM;
      cycle_cnt         = 0;
      num_rows          = 0;
      rng_state         = 32'hc421a49c;
      for (int ch = 0; ch < NUM_CH; ch++) begin
         rng_state     = lcg_next(rng_state);
         start_dly[ch] = int'(rng_state[19:16]);  // random phase
         cur_half[ch] <= 0;
         ph_cnt[ch]    = 0;
         prev_half[ch] = -1;
      end

      //      name                 h0 h1 h2 lim dis led sel win chg
      add_row("measure_ch0",       2, 4, 8, 40, 1'b0, 0, 0, 3, 3'b000, LED_ANY, 1'b0, 1'b0);
      add_row("measure_ch1",       2, 4, 8, 40, 1'b0, 2, 1, 2, 3'b000, LED_EXACT, 1'b1, 1'b0);
      add_row("measure_ch2",       2, 4, 8, 40, 1'b0, 3, 2, 2, 3'b000, LED_EXACT, 1'b1, 1'b0);
      add_row("stop_ch2",          2, 4, 0, 40, 1'b0, 3, 2, 3, 3'b000, LED_EXACT, 1'b0, 1'b0);
      add_row("alive_ch0",         2, 4, 0, 40, 1'b0, 1, 0, 1, 3'b000, LED_EXACT, 1'b1, 1'b0);
      add_row("change_ch1",        2, 2, 0, 4, 1'b0, 2, 1, 3, 3'b010, LED_EXACT, 1'b1, 1'b1);
      add_row("led_system",        2, 2, 0, 4, 1'b0, 0, 1, 2, 3'b010, LED_EQUAL, 1'b0, 1'b0);
      add_row("clear_disable",     2, 2, 0, 4, 1'b1, 2, 1, 1, 3'b000, LED_EXACT, 1'b1, 1'b0);
      add_row("no_flag_disabled",  2, 4, 0, 4, 1'b1, 2, 1, 3, 3'b000, LED_EXACT, 1'b1, 1'b0);
      add_row("reenable_stable",   2, 4, 0, 4, 1'b0, 2, 1, 2, 3'b000, LED_EXACT, 1'b1, 1'b0);
      add_row("change_limit_high", 2, 2, 0, 40, 1'b0, 2, 1, 3, 3'b000, LED_EXACT, 1'b1, 1'b0);

      total_win = 0;
      for (int r = 0; r < num_rows; r++) begin
         total_win += row_nwin[r];
      end
      cycle_limit = total_win * WINDOW + 500;

      repeat (4) @(negedge clk_usb);
      reset = 1'b0;

      for (int r = 0; r < num_rows; r++) begin
         changed = 1'b0;
         for (int ch = 0; ch < NUM_CH; ch++) begin
            if (row_half[r][ch] != prev_half[ch]) begin
               changed = 1'b1;
            end
         end
         apply_row(r);
         for (int w = 0; w < row_nwin[r]; w++) begin
            wait_valid(row_name[r]);
            if (!(changed && w == 0)) begin  // first window is mixed
               check_freq(r);
            end
            if (row_dis[r]) begin
               assert (change_o == '0)
                  else fail_run($sformatf("mismatch %s change_o: expected %b actual %b",
                                          row_name[r], 3'b000, change_o));
            end
         end
         check_row_end(r);
         for (int ch = 0; ch < NUM_CH; ch++) begin
            prev_half[ch] = row_half[r][ch];
         end
      end

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire
